// File: hdl/axi_wr_pkg.sv
`default_nettype none

// AXI write channel widths and response codes
package axi_wr_pkg;

    // ------------------------------
    // Field widths
    // ------------------------------
    localparam int unsigned ID_WIDTH   = 4;
    localparam int unsigned RESP_WIDTH = 2;

    typedef logic [ID_WIDTH-1:0]   axi_id_t;
    typedef logic [RESP_WIDTH-1:0] axi_resp_t;

    // ------------------------------
    // BRESP encodings
    // ------------------------------
    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

// File: hdl/slave_model_pkg.sv
`default_nettype none

// Slave model sizing, slot types and response delay rule
package slave_model_pkg;

    // Outstanding slot table
    localparam int unsigned OST_DEPTH = 8;
    localparam int unsigned PTR_WIDTH = $clog2(OST_DEPTH);

    typedef logic [OST_DEPTH-1:0] slot_vec_t;
    typedef logic [PTR_WIDTH-1:0] slot_ptr_t;

    // ------------------------------
    // Response delay rule
    // ------------------------------
    // Slot with ID n is ready once its counter reaches MAX_RESP_DLY - 2n
    localparam int unsigned MAX_RESP_DLY = 31;
    localparam int unsigned DLY_WIDTH    = $clog2(MAX_RESP_DLY + 1);

    typedef logic [DLY_WIDTH-1:0] dly_cnt_t;

    // This ID always gets SLVERR
    localparam axi_wr_pkg::axi_id_t ERR_ID = 4'd15;

    // First set bit of req at or after start with wraparound
    function automatic slot_ptr_t rr_pick(slot_vec_t req, slot_ptr_t start);
        slot_ptr_t idx;
        slot_ptr_t pick;
        pick = start;
        // Walk down so the nearest candidate is the last one written
        for (int i = OST_DEPTH - 1; i >= 0; i--) begin
            idx = start + slot_ptr_t'(i);
            if (req[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

endpackage

`default_nettype wire

// File: hdl/slot_alloc.sv
`timescale 1ns/10ps
`default_nettype none

module slot_alloc (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       awvalid,
    input  logic                       wvalid,
    input  logic                       wlast,
    input  slave_model_pkg::slot_vec_t busy,
    output logic                       awready,
    output slave_model_pkg::slot_vec_t alloc_vec,
    output slave_model_pkg::slot_vec_t beat_vec,
    output slave_model_pkg::slot_vec_t last_vec
);

    slave_model_pkg::slot_vec_t free_vec;
    slave_model_pkg::slot_ptr_t alloc_ptr_q;
    slave_model_pkg::slot_ptr_t pick_ptr;

    // Slot order queue for the W channel
    slave_model_pkg::slot_ptr_t q_mem [slave_model_pkg::OST_DEPTH];
    slave_model_pkg::slot_ptr_t q_wr_q;
    slave_model_pkg::slot_ptr_t q_rd_q;
    slave_model_pkg::slot_ptr_t q_head;
    logic [$clog2(slave_model_pkg::OST_DEPTH + 1)-1:0] q_cnt_q;

    logic q_empty;
    logic aw_fire;
    logic w_pop;

    // ------------------------------
    // Free slot pick
    // ------------------------------
    assign free_vec = ~busy;
    assign awready  = |free_vec;
    assign pick_ptr = slave_model_pkg::rr_pick(free_vec, alloc_ptr_q);
    assign aw_fire  = awvalid & awready;

    assign alloc_vec = aw_fire ? (slave_model_pkg::slot_vec_t'(1) << pick_ptr) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alloc_ptr_q <= '0;
        end else if (aw_fire) begin
            // Start the next search just past the slot taken
            alloc_ptr_q <= pick_ptr + slave_model_pkg::slot_ptr_t'(1);
        end
    end

    // ------------------------------
    // Data order queue
    // ------------------------------
    assign q_empty = (q_cnt_q == '0);
    assign q_head  = q_mem[q_rd_q];

    // Beats with nothing queued are orphans and go nowhere
    assign beat_vec = (wvalid && !q_empty) ?
                      (slave_model_pkg::slot_vec_t'(1) << q_head) : '0;
    assign last_vec = wlast ? beat_vec : '0;
    assign w_pop    = wvalid & wlast & ~q_empty;

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            q_mem[q_wr_q] <= pick_ptr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wr_q  <= '0;
            q_rd_q  <= '0;
            q_cnt_q <= '0;
        end else begin
            if (aw_fire) begin
                q_wr_q <= q_wr_q + slave_model_pkg::slot_ptr_t'(1);
            end
            if (w_pop) begin
                q_rd_q <= q_rd_q + slave_model_pkg::slot_ptr_t'(1);
            end
            // Entries never outnumber busy slots so the count cannot overflow
            case ({aw_fire, w_pop})
                2'b10:   q_cnt_q <= q_cnt_q + 1'b1;
                2'b01:   q_cnt_q <= q_cnt_q - 1'b1;
                default: q_cnt_q <= q_cnt_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/wr_slot.sv
`timescale 1ns/10ps
`default_nettype none

module wr_slot (
    input  logic                  clk,
    input  logic                  rst_n,
    input  axi_wr_pkg::axi_id_t   awid,
    input  logic                  alloc,
    input  logic                  beat,
    input  logic                  last,
    input  logic                  release_slot,
    output logic                  busy,
    output logic                  ready,
    output axi_wr_pkg::axi_id_t   slot_id,
    output axi_wr_pkg::axi_resp_t slot_resp
);

    slave_model_pkg::dly_cnt_t dly_cnt;
    slave_model_pkg::dly_cnt_t dly_target;
    logic                      dly_run;
    logic                      dly_hit;
    logic                      burst_done;

    // Final beat of this slot's burst
    assign burst_done = beat & last;

    // Higher IDs answer sooner
    assign dly_target = slave_model_pkg::dly_cnt_t'(slave_model_pkg::MAX_RESP_DLY) -
                        slave_model_pkg::dly_cnt_t'({slot_id, 1'b0});
    assign dly_hit    = dly_run & (dly_cnt == dly_target);

    // ------------------------------
    // Slot state and delay counter
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            ready   <= 1'b0;
            dly_run <= 1'b0;
            dly_cnt <= '0;
        end else if (alloc) begin
            busy    <= 1'b1;
            ready   <= 1'b0;
            dly_run <= 1'b0;
            dly_cnt <= '0;
        end else if (release_slot) begin
            busy    <= 1'b0;
            ready   <= 1'b0;
            dly_run <= 1'b0;
        end else if (burst_done) begin
            // Count from one so the edge taking wlast is cycle one
            dly_run <= 1'b1;
            dly_cnt <= slave_model_pkg::dly_cnt_t'(1);
        end else if (dly_hit) begin
            dly_run <= 1'b0;
            ready   <= 1'b1;
        end else if (dly_run) begin
            dly_cnt <= dly_cnt + slave_model_pkg::dly_cnt_t'(1);
        end
    end

    // ------------------------------
    // Captured ID and response
    // ------------------------------
    always_ff @(posedge clk) begin
        if (alloc) begin
            slot_id <= awid;
        end
        if (burst_done) begin
            slot_resp <= (slot_id == slave_model_pkg::ERR_ID) ?
                         axi_wr_pkg::RESP_SLVERR : axi_wr_pkg::RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// File: hdl/resp_order.sv
`timescale 1ns/10ps
`default_nettype none

module resp_order (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       bready,
    input  slave_model_pkg::slot_vec_t alloc_vec,
    input  slave_model_pkg::slot_vec_t busy,
    input  slave_model_pkg::slot_vec_t ready,
    input  axi_wr_pkg::axi_id_t        slot_id [slave_model_pkg::OST_DEPTH],
    input  axi_wr_pkg::axi_resp_t      slot_resp [slave_model_pkg::OST_DEPTH],
    output logic                       bvalid,
    output axi_wr_pkg::axi_id_t        bid,
    output axi_wr_pkg::axi_resp_t      bresp,
    output slave_model_pkg::slot_vec_t release_vec
);

    // Row i holds the slots allocated before slot i
    slave_model_pkg::slot_vec_t older_q [slave_model_pkg::OST_DEPTH];

    slave_model_pkg::slot_vec_t blocked;
    slave_model_pkg::slot_vec_t eligible;
    slave_model_pkg::slot_ptr_t rr_q;
    slave_model_pkg::slot_ptr_t pick_ptr;
    slave_model_pkg::slot_ptr_t sel_ptr;
    slave_model_pkg::slot_ptr_t lock_ptr_q;
    logic                       lock_q;
    logic                       b_fire;

    // ------------------------------
    // Age matrix
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < slave_model_pkg::OST_DEPTH; i++) begin
                older_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < slave_model_pkg::OST_DEPTH; i++) begin
                if (alloc_vec[i]) begin
                    older_q[i] <= busy;
                end else begin
                    // A reused slot is younger than everyone
                    older_q[i] <= older_q[i] & ~alloc_vec;
                end
            end
        end
    end

    // Held back by an older busy slot with the same ID
    always_comb begin
        for (int i = 0; i < slave_model_pkg::OST_DEPTH; i++) begin
            blocked[i] = 1'b0;
            for (int j = 0; j < slave_model_pkg::OST_DEPTH; j++) begin
                if (older_q[i][j] && busy[j] && (slot_id[j] == slot_id[i])) begin
                    blocked[i] = 1'b1;
                end
            end
        end
    end

    assign eligible = ready & ~blocked;

    // ------------------------------
    // Pick and B channel
    // ------------------------------
    assign pick_ptr = slave_model_pkg::rr_pick(eligible, rr_q);

    // Stalled response keeps its slot until bready
    assign sel_ptr = lock_q ? lock_ptr_q : pick_ptr;

    assign bvalid = lock_q | (|eligible);
    assign bid    = slot_id[sel_ptr];
    assign bresp  = slot_resp[sel_ptr];
    assign b_fire = bvalid & bready;

    assign release_vec = b_fire ? (slave_model_pkg::slot_vec_t'(1) << sel_ptr) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_q       <= '0;
            lock_q     <= 1'b0;
            lock_ptr_q <= '0;
        end else begin
            lock_q     <= bvalid & ~bready;
            lock_ptr_q <= sel_ptr;
            if (b_fire) begin
                rr_q <= sel_ptr + slave_model_pkg::slot_ptr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/axi_slv_wr_top.sv
`timescale 1ns/10ps
`default_nettype none

module axi_slv_wr_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // AW channel
    input  axi_wr_pkg::axi_id_t   awid,
    input  logic                  awvalid,
    output logic                  awready,

    // W channel
    input  logic                  wvalid,
    input  logic                  wlast,
    output logic                  wready,

    // B channel
    output axi_wr_pkg::axi_id_t   bid,
    output axi_wr_pkg::axi_resp_t bresp,
    output logic                  bvalid,
    input  logic                  bready
);

    slave_model_pkg::slot_vec_t alloc_vec;
    slave_model_pkg::slot_vec_t beat_vec;
    slave_model_pkg::slot_vec_t last_vec;
    slave_model_pkg::slot_vec_t busy;
    slave_model_pkg::slot_vec_t ready;
    slave_model_pkg::slot_vec_t release_vec;

    axi_wr_pkg::axi_id_t   slot_id   [slave_model_pkg::OST_DEPTH];
    axi_wr_pkg::axi_resp_t slot_resp [slave_model_pkg::OST_DEPTH];

    // Data is always taken
    assign wready = 1'b1;

    // ------------------------------
    // Address and data bookkeeping
    // ------------------------------
    slot_alloc u_slot_alloc (
        .clk       (clk),
        .rst_n     (rst_n),
        .awvalid   (awvalid),
        .wvalid    (wvalid),
        .wlast     (wlast),
        .busy      (busy),
        .awready   (awready),
        .alloc_vec (alloc_vec),
        .beat_vec  (beat_vec),
        .last_vec  (last_vec)
    );

    // Outstanding write slots
    for (genvar i = 0; i < slave_model_pkg::OST_DEPTH; i++) begin : g_slot
        wr_slot u_wr_slot (
            .clk          (clk),
            .rst_n        (rst_n),
            .awid         (awid),
            .alloc        (alloc_vec[i]),
            .beat         (beat_vec[i]),
            .last         (last_vec[i]),
            .release_slot (release_vec[i]),
            .busy         (busy[i]),
            .ready        (ready[i]),
            .slot_id      (slot_id[i]),
            .slot_resp    (slot_resp[i])
        );
    end

    // ------------------------------
    // Response selection
    // ------------------------------
    resp_order u_resp_order (
        .clk         (clk),
        .rst_n       (rst_n),
        .bready      (bready),
        .alloc_vec   (alloc_vec),
        .busy        (busy),
        .ready       (ready),
        .slot_id     (slot_id),
        .slot_resp   (slot_resp),
        .bvalid      (bvalid),
        .bid         (bid),
        .bresp       (bresp),
        .release_vec (release_vec)
    );

endmodule

`default_nettype wire

// File: dv/axi_slv_wr_tb.sv
`timescale 1ns/10ps
`default_nettype none

module axi_slv_wr_tb;

    localparam int NUM_BURSTS = 60;
    localparam int MAX_WR     = 128;
    localparam int NUM_IDS    = 1 << axi_wr_pkg::ID_WIDTH;

    logic                  clk;
    logic                  rst_n;
    axi_wr_pkg::axi_id_t   awid;
    logic                  awvalid;
    logic                  awready;
    logic                  wvalid;
    logic                  wlast;
    logic                  wready;
    axi_wr_pkg::axi_id_t   bid;
    axi_wr_pkg::axi_resp_t bresp;
    logic                  bvalid;
    logic                  bready;

    // Driver state
    int aw_left     = 0;
    int aw_len      = 0;
    int beat_left   = 0;
    int bready_mode = 0;
    bit aw_taken    = 1'b0;
    bit w_enable    = 1'b0;
    int len_q [$];

    // Scoreboard state
    int                    edge_idx   = 0;
    int                    wr_count   = 0;
    int                    resp_count = 0;
    bit                    hold_q     = 1'b0;
    axi_wr_pkg::axi_id_t   held_bid;
    axi_wr_pkg::axi_resp_t held_bresp;
    int                    id_q [NUM_IDS][$];
    int                    addr_q [$];
    int                    wlast_edge [MAX_WR];
    bit                    wlast_seen [MAX_WR];

    always #4 clk = ~clk;

    axi_slv_wr_top axi_slv_wr_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .awid    (awid),
        .awvalid (awvalid),
        .awready (awready),
        .wvalid  (wvalid),
        .wlast   (wlast),
        .wready  (wready),
        .bid     (bid),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic axi_wr_pkg::axi_resp_t exp_resp(input axi_wr_pkg::axi_id_t id);
        if (id == slave_model_pkg::ERR_ID) begin
            return axi_wr_pkg::RESP_SLVERR;
        end
        return axi_wr_pkg::RESP_OKAY;
    endfunction

    // Edges between wlast and the earliest bvalid
    function automatic int min_resp_dly(input axi_wr_pkg::axi_id_t id);
        return int'(slave_model_pkg::MAX_RESP_DLY) - 2 * int'(id);
    endfunction

    // ------------------------------
    // Failure reporting and compares
    // ------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_bid(input string name, input axi_wr_pkg::axi_id_t exp,
                             input axi_wr_pkg::axi_id_t act);
        if (act !== exp) begin
            report_failure($sformatf("** Error %s expected 0x%0h got 0x%0h", name, exp, act));
        end
    endtask

    task automatic check_bresp(input string name, input axi_wr_pkg::axi_resp_t exp,
                               input axi_wr_pkg::axi_resp_t act);
        if (act !== exp) begin
            report_failure($sformatf("** Error %s expected 0x%0h got 0x%0h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("** Error %s expected 0x%0h got 0x%0h", name, exp, act));
        end
    endtask

    // ------------------------------
    // Stimulus driven on each falling edge
    // ------------------------------
    task automatic drive_cycle();
        // Address taken at the last edge is withdrawn
        if (aw_taken) begin
            awvalid  = 1'b0;
            aw_taken = 1'b0;
        end
        // One beat of the oldest accepted burst with random gaps
        wvalid = 1'b0;
        wlast  = 1'b0;
        if (w_enable && (beat_left > 0 || len_q.size() > 0) && ($urandom % 4 != 0)) begin
            if (beat_left == 0) begin
                beat_left = len_q.pop_front();
            end
            wvalid    = 1'b1;
            wlast     = (beat_left == 1);
            beat_left = beat_left - 1;
        end
        if (!awvalid && aw_left > 0 && ($urandom % 3 != 0)) begin
            awvalid = 1'b1;
            awid    = axi_wr_pkg::axi_id_t'($urandom);
            aw_len  = 1 + ($urandom % 8);
        end
        // Data of this burst may start from the next cycle
        if (awvalid && awready) begin
            len_q.push_back(aw_len);
            aw_left  = aw_left - 1;
            aw_taken = 1'b1;
        end
        case (bready_mode)
            0:       bready = 1'b0;
            1:       bready = 1'b1;
            default: bready = ($urandom % 3 != 0);
        endcase
    endtask

    task automatic step_cycle();
        @(negedge clk);
        drive_cycle();
    endtask

    // ------------------------------
    // Scoreboard
    // ------------------------------
    task automatic score_resp();
        int s;
        if (id_q[bid].size() == 0) begin
            report_failure($sformatf("Response with ID 0x%0h matches no outstanding write", bid));
        end
        s = id_q[bid].pop_front();
        check_bresp("bresp", exp_resp(bid), bresp);
        if (!wlast_seen[s]) begin
            report_failure($sformatf("Response for write %0d came before its last beat", s));
        end
        if (edge_idx - wlast_edge[s] <= min_resp_dly(bid)) begin
            report_failure($sformatf("Response for write %0d came %0d cycles after wlast",
                                     s, edge_idx - wlast_edge[s]));
        end
        resp_count++;
    endtask

    // Looks at the values that the next rising edge will see
    task automatic sample_cycle();
        int s;
        edge_idx++;
        // Stalled response must not move
        if (hold_q) begin
            check_flag("bvalid", 1'b1, bvalid);
            check_bid("bid", held_bid, bid);
            check_bresp("bresp", held_bresp, bresp);
        end
        hold_q     = bvalid && !bready;
        held_bid   = bid;
        held_bresp = bresp;
        if (bvalid && bready) begin
            score_resp();
        end
        // Beats without an earlier address are orphans
        if (wvalid && wlast && addr_q.size() > 0) begin
            s = addr_q.pop_front();
            wlast_edge[s] = edge_idx;
            wlast_seen[s] = 1'b1;
        end
        if (awvalid && awready) begin
            if (wr_count >= MAX_WR) begin
                report_failure("More writes issued than the scoreboard can hold");
            end
            id_q[awid].push_back(wr_count);
            addr_q.push_back(wr_count);
            wr_count++;
        end
    endtask

    initial begin : compare_proc
        forever begin
            @(negedge clk);
            #1;
            if (rst_n) begin
                sample_cycle();
            end
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : main_proc
        int cycles;
        void'($urandom(80));
        clk      = 1'b0;
        rst_n    = 1'b0;
        awid     = '0;
        awvalid  = 1'b0;
        wvalid   = 1'b0;
        wlast    = 1'b0;
        bready   = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Idle state after reset
        @(negedge clk);
        check_flag("bvalid", 1'b0, bvalid);
        check_flag("awready", 1'b1, awready);
        check_flag("wready", 1'b1, wready);

        // Fill every slot with addresses only
        aw_left = slave_model_pkg::OST_DEPTH;
        cycles  = 0;
        while (aw_left > 0) begin
            step_cycle();
            cycles++;
            if (cycles > 100) begin
                report_failure("Timed out filling all slots with addresses");
            end
        end
        step_cycle();
        check_flag("awready", 1'b0, awready);

        // Send the data and let one response through
        w_enable    = 1'b1;
        bready_mode = 1;
        cycles      = 0;
        while (resp_count == 0) begin
            step_cycle();
            #2;
            cycles++;
            if (cycles > 300) begin
                report_failure("Timed out waiting for the first response");
            end
        end
        step_cycle();
        check_flag("awready", 1'b1, awready);

        // Random traffic with random bready
        aw_left     = NUM_BURSTS;
        bready_mode = 2;
        cycles      = 0;
        while (aw_left > 0 || len_q.size() > 0 || beat_left > 0 || resp_count != wr_count) begin
            step_cycle();
            #2;
            cycles++;
            if (cycles > 20000) begin
                report_failure("Timed out waiting for all responses");
            end
        end
        step_cycle();

        if (resp_count != wr_count ||
            wr_count != slave_model_pkg::OST_DEPTH + NUM_BURSTS) begin
            report_failure($sformatf("Got %0d responses for %0d writes", resp_count, wr_count));
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/axi_wr_pkg.sv
hdl/slave_model_pkg.sv
hdl/slot_alloc.sv
hdl/wr_slot.sv
hdl/resp_order.sv
hdl/axi_slv_wr_top.sv
dv/axi_slv_wr_tb.sv

// File: Bender.yml
package:
  name: axi_slv_wr

sources:
  # Packages first, the slot model depends on the AXI widths
  - hdl/axi_wr_pkg.sv
  - hdl/slave_model_pkg.sv
  # Design
  - hdl/slot_alloc.sv
  - hdl/wr_slot.sv
  - hdl/resp_order.sv
  - hdl/axi_slv_wr_top.sv
  # Testbench
  - target: test
    files:
      - dv/axi_slv_wr_tb.sv
